/* verilog.f */
src/iq_rx_pkg.sv
src/lvds_rx_deframer.sv
src/iq_sample_fifo.sv
src/smi_rx_reader.sv
src/cariboulite_rx_top.sv
tb/tb_cariboulite_rx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the receive path testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_cariboulite_rx &&
{ sim_out=$(./obj_dir/Vtb_cariboulite_rx) ; printf '%s\n' "$sim_out" ; } &&
printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED" ||
{ echo "Simulation did not pass" ; exit 1 ; }

/* tb/tb_cariboulite_rx.sv */
`timescale 1ns/1ps

module tb_cariboulite_rx import iq_rx_pkg::*; ();

  // ==========================================================================
  // Run length, DUT signals and model state
  // ==========================================================================
  localparam int FRAMES_T2       = 40;
  localparam int FRAMES_T3       = 40;
  localparam int FRAMES_T4       = 30;
  localparam int FRAMES_T5       = FIFO_DEPTH + 5;  // Overfills reader plus FIFO
  localparam int TOTAL_FRAMES    = FRAMES_T2 + FRAMES_T3 + FRAMES_T4 + FRAMES_T5;
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * DIBITS_PER_FRAME * 4 + 40000;

  logic                  glob_clock = 1'b0;
  logic                  rst_b;
  logic                  rx_09_d0;
  logic                  rx_09_d1;
  logic                  rx_24_d0;
  logic                  rx_24_d1;
  rx_channel_e           channel;        // DUT input, changes only after an edge
  rx_channel_e           want_channel;   // Set by the tests
  logic                  smi_soe_se;
  logic [SMI_BYTE_W-1:0] smi_data;
  logic                  smi_read_req;

  logic [31:0]           lfsr = 32'h9bbb;
  logic [SAMPLE_W-1:0]   exp_q [$];      // Samples the host should see, in order
  logic                  host_en = 1'b0;
  int                    checks = 0;
  int                    errors = 0;
  int                    err_mark;
  logic                  m_collect;      // Model of the hunting rule
  int                    m_cnt;
  logic [SAMPLE_W-1:0]   m_word;
  rx_channel_e           m_prev_ch;

  cariboulite_rx_top cariboulite_rx_top_i (
    .i_glob_clock   (glob_clock),
    .i_rst_b        (rst_b),
    .i_rx_09_d0     (rx_09_d0),
    .i_rx_09_d1     (rx_09_d1),
    .i_rx_24_d0     (rx_24_d0),
    .i_rx_24_d1     (rx_24_d1),
    .i_channel      (channel),
    .i_smi_soe_se   (smi_soe_se),
    .o_smi_data     (smi_data),
    .o_smi_read_req (smi_read_req)
  );

  always #4 glob_clock = ~glob_clock;  // 8 ns period

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // Random payload behind the markers, Q marker spoiled on request
  function automatic iq_sample_t make_frame(input logic good_q);
    iq_sample_t s;
    logic [1:0] q_sync;
    q_sync = good_q ? SYNC_Q : 2'(rand_bits(2));
    if (!good_q && q_sync == SYNC_Q) q_sync = 2'b11;
    s.i = {SYNC_I, 14'(rand_bits(14))};
    s.q = {q_sync, 14'(rand_bits(14))};
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR at %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  // Hunt for SYNC_I, take sixteen dibits, keep the word if SYNC_Q sits on top of Q
  task automatic model_step(input logic [1:0] d);
    if (channel != m_prev_ch) begin
      m_collect = 1'b0;  // Lane switch throws away a partial frame
      m_cnt     = 0;
    end else if (!m_collect) begin
      if (d == SYNC_I) begin
        m_collect = 1'b1;
        m_cnt     = 1;
        m_word    = {30'b0, d};
      end
    end else begin
      m_word = {m_word[SAMPLE_W-3:0], d};
      m_cnt++;
      if (m_cnt == DIBITS_PER_FRAME) begin
        m_collect = 1'b0;
        // Room is one sample in the reader plus the FIFO depth
        if (m_word[HALF_W-1 -: 2] == SYNC_Q && exp_q.size() < FIFO_DEPTH + 1) begin
          exp_q.push_back(m_word);
        end
      end
    end
    m_prev_ch = channel;
  endtask

  // One clock on both lanes, d24 given un-inverted
  task automatic drive_dibit(input logic [1:0] d09, input logic [1:0] d24);
    @(posedge glob_clock);
    #1;
    channel  = want_channel;
    rx_09_d0 = d09[1];
    rx_09_d1 = d09[0];
    rx_24_d0 = ~d24[1];  // Board inverts this lane
    rx_24_d1 = ~d24[0];
    model_step((channel == RX_CH_24) ? d24 : d09);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) drive_dibit(2'b00, 2'b00);
  endtask

  task automatic drive_garbage(input int n);
    repeat (n) drive_dibit(2'(rand_bits(2)), 2'b00);
  endtask

  // MSB first, d0 carries the upper bit of each pair
  task automatic send_frame(input logic [31:0] w09, input logic [31:0] w24);
    for (int k = 0; k < DIBITS_PER_FRAME; k++) begin
      drive_dibit(w09[31-2*k -: 2], w24[31-2*k -: 2]);
    end
  endtask

  // Idle lanes until the host has taken every expected sample, then watch for extras
  task automatic drain_host();
    while (exp_q.size() != 0 || smi_read_req) drive_idle(1);
    drive_idle(64);
  endtask

  // ==========================================================================
  // SMI host, four strobes per sample
  // ==========================================================================
  task automatic read_sample();
    logic [SAMPLE_W-1:0] exp;
    logic                have_exp;
    int                  gap;
    int                  low_cycles;
    have_exp = (exp_q.size() != 0);
    exp      = '0;
    checks++;
    assert (have_exp) else begin
      errors++;
      $display("DUT offered a sample at %0d ns that the model did not expect", $time);
    end
    if (have_exp) exp = exp_q.pop_front();
    for (int b = 0; b < BYTES_PER_SAMPLE; b++) begin
      if (b > 0) check_value("o_smi_read_req", 1, smi_read_req);  // Held between bytes
      if (have_exp) check_value("o_smi_data", exp[SAMPLE_W-1-SMI_BYTE_W*b -: SMI_BYTE_W], smi_data);
      gap = int'(rand_bits(2));  // Host think time
      repeat (gap) @(negedge glob_clock);
      @(posedge glob_clock);
      #1;
      smi_soe_se = 1'b0;
      low_cycles = 2 + int'(rand_bits(1));
      repeat (low_cycles) @(posedge glob_clock);
      #1;
      smi_soe_se = 1'b1;
      repeat (4) @(posedge glob_clock);  // Two sync flops, edge flop, byte step
      @(negedge glob_clock);
    end
    check_value("o_smi_read_req", 0, smi_read_req);  // Drops after the fourth byte
  endtask

  initial begin
    wait (rst_b === 1'b1);
    forever begin
      @(negedge glob_clock);  // Outputs settled here
      if (host_en && smi_read_req) read_sample();
      else if (!smi_read_req) check_value("o_smi_data", 0, smi_data);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge glob_clock);
    $display("Run timed out after %0d cycles with %0d samples still expected",
             WATCHDOG_CYCLES, exp_q.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic report_test(input int num, input string name, input int mark);
    $display("Test %0d %s: %0d errors", num, name, errors - mark);
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    rst_b = 1'b0;
    {rx_09_d0, rx_09_d1, rx_24_d0, rx_24_d1} = 4'b0011;  // Both lanes idle
    channel      = RX_CH_09;
    want_channel = RX_CH_09;
    smi_soe_se   = 1'b1;
    m_collect    = 1'b0;
    m_cnt        = 0;
    m_word       = '0;
    m_prev_ch    = RX_CH_09;
    repeat (16) @(posedge glob_clock);
    #1;
    rst_b = 1'b1;

    err_mark = errors;
    for (int n = 0; n < 40; n++) begin
      drive_idle(1);
      @(negedge glob_clock);
      check_value("o_smi_read_req", 0, smi_read_req);
      check_value("o_smi_data", 0, smi_data);
    end
    report_test(1, "reset and idle lanes", err_mark);
    host_en = 1'b1;

    err_mark = errors;
    for (int n = 0; n < FRAMES_T2; n++) begin
      send_frame(make_frame(1'b1), '0);
      drive_idle(rand_bits(1) ? int'(rand_bits(3)) : 0);  // Half back to back
    end
    drain_host();
    report_test(2, "valid frames on the 0.9 GHz lane", err_mark);

    err_mark = errors;
    for (int n = 0; n < FRAMES_T3; n++) begin
      send_frame(make_frame(rand_bits(2) != 0), '0);  // One in four with a bad Q marker
      drive_garbage(int'(rand_bits(3)));
    end
    drain_host();
    report_test(3, "bad Q sync and garbage between frames", err_mark);

    err_mark = errors;
    drive_idle(DIBITS_PER_FRAME);  // No partial frame across the switch
    want_channel = RX_CH_24;
    drive_idle(4);
    for (int n = 0; n < FRAMES_T4; n++) begin
      send_frame(make_frame(1'b1), make_frame(1'b1));  // 0.9 GHz lane busy but unselected
      drive_idle(int'(rand_bits(2)));
    end
    drain_host();
    want_channel = RX_CH_09;
    drive_idle(4);
    report_test(4, "inverted 2.4 GHz lane selected", err_mark);

    err_mark = errors;
    host_en  = 1'b0;
    for (int n = 0; n < FRAMES_T5; n++) begin
      send_frame(make_frame(1'b1), '0);
      drive_idle(int'(rand_bits(1)));
    end
    drive_idle(8);
    check_value("o_smi_read_req", 1, smi_read_req);
    host_en = 1'b1;
    drain_host();
    report_test(5, "back-pressure with the host stalled", err_mark);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* src/cariboulite_rx_top.sv */
`timescale 1ns/1ps

module cariboulite_rx_top import iq_rx_pkg::*; (
  input  logic                  i_glob_clock,
  input  logic                  i_rst_b,

  // Modem I/Q lanes
  input  logic                  i_rx_09_d0,
  input  logic                  i_rx_09_d1,
  input  logic                  i_rx_24_d0,   // Arrives inverted
  input  logic                  i_rx_24_d1,   // Arrives inverted
  input  rx_channel_e           i_channel,

  // SMI host, read direction only
  input  logic                  i_smi_soe_se,
  output logic [SMI_BYTE_W-1:0] o_smi_data,
  output logic                  o_smi_read_req
);

  // ==========================================================================
  // Internal wiring
  // ==========================================================================
  logic       w_push;         // Deframer to FIFO
  iq_sample_t w_wr_sample;
  logic       w_fifo_full;
  logic       w_pull;         // Reader to FIFO
  iq_sample_t w_rd_sample;
  logic       w_fifo_empty;

  // Input side, lane select and deframing
  lvds_rx_deframer lvds_rx_deframer_i (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_rx_09_d0   (i_rx_09_d0),
    .i_rx_09_d1   (i_rx_09_d1),
    .i_rx_24_d0   (i_rx_24_d0),
    .i_rx_24_d1   (i_rx_24_d1),
    .i_channel    (i_channel),
    .i_fifo_full  (w_fifo_full),
    .o_push       (w_push),
    .o_sample     (w_wr_sample)
  );

  // Sample buffer, 1024 deep
  iq_sample_fifo iq_sample_fifo_i (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_push       (w_push),
    .i_wr_sample  (w_wr_sample),
    .i_pull       (w_pull),
    .o_rd_sample  (w_rd_sample),
    .o_full       (w_fifo_full),
    .o_empty      (w_fifo_empty)
  );

  // Output side, byte serving to the host
  smi_rx_reader smi_rx_reader_i (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_fifo_empty   (w_fifo_empty),
    .i_fifo_sample  (w_rd_sample),
    .o_fifo_pull    (w_pull),
    .i_smi_soe_se   (i_smi_soe_se),
    .o_smi_data     (o_smi_data),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

/* src/smi_rx_reader.sv */
`timescale 1ns/1ps

module smi_rx_reader import iq_rx_pkg::*; (
  input  logic                  i_glob_clock,
  input  logic                  i_rst_b,

  // Sample FIFO read side
  input  logic                  i_fifo_empty,
  input  iq_sample_t            i_fifo_sample,
  output logic                  o_fifo_pull,

  // SMI host
  input  logic                  i_smi_soe_se,    // Async, active low read strobe
  output logic [SMI_BYTE_W-1:0] o_smi_data,
  output logic                  o_smi_read_req
);

  // ==========================================================================
  // Read strobe synchronizer and edge detect
  // ==========================================================================
  logic [1:0] r_soe_sync;  // Two flop synchronizer
  logic       r_soe_prev;  // Last synchronized level
  logic       r_soe_rise;  // One cycle per rising edge

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      // Strobe idles high
      r_soe_sync <= 2'b11;
      r_soe_prev <= 1'b1;
      r_soe_rise <= 1'b0;
    end else begin
      r_soe_sync <= {r_soe_sync[0], i_smi_soe_se};
      r_soe_prev <= r_soe_sync[1];
      r_soe_rise <= r_soe_sync[1] && !r_soe_prev;  // Host done with the byte
    end
  end

  // ==========================================================================
  // Fetch / serve state machine
  // ==========================================================================
  reader_state_e         r_state;
  logic [BYTE_IDX_W-1:0] r_byte_idx;  // 0 selects bits 31:24
  iq_sample_t            r_sample;    // Sample held for the host
  logic                  w_last_byte;
  logic                  w_serving;
  logic [SMI_BYTE_W-1:0] w_byte;

  assign w_last_byte = (r_byte_idx == BYTE_IDX_W'(BYTES_PER_SAMPLE - 1));
  assign w_serving   = (r_state == RD_SERVE);

  // Pull in the same cycle the FIFO shows data
  assign o_fifo_pull = (r_state == RD_IDLE) && !i_fifo_empty;

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_state    <= RD_IDLE;
      r_byte_idx <= '0;
    end else begin
      case (r_state)
        RD_IDLE: begin
          if (!i_fifo_empty) begin
            r_state <= RD_FETCH;  // FIFO read data shows up next cycle
          end
        end

        RD_FETCH: begin
          r_state    <= RD_SERVE;
          r_byte_idx <= '0;
        end

        RD_SERVE: begin
          if (r_soe_rise) begin
            if (w_last_byte) begin
              r_state    <= RD_IDLE;  // All four bytes taken
              r_byte_idx <= '0;
            end else begin
              r_byte_idx <= r_byte_idx + 1'b1;
            end
          end
        end

        default: begin
          r_state    <= RD_IDLE;
          r_byte_idx <= '0;
        end
      endcase
    end
  end

  // Sample latch, payload only
  always_ff @(posedge i_glob_clock) begin
    if (r_state == RD_FETCH) begin
      r_sample <= i_fifo_sample;
    end
  end

  // ==========================================================================
  // Byte output
  // ==========================================================================
  // Most significant byte first
  assign w_byte = r_sample[SAMPLE_W - SMI_BYTE_W * (int'(r_byte_idx) + 1) +: SMI_BYTE_W];

  assign o_smi_read_req = w_serving;                 // High while a sample is held
  assign o_smi_data     = w_serving ? w_byte : '0;   // Quiet bus when nothing to read

endmodule

/* src/iq_sample_fifo.sv */
`timescale 1ns/1ps

module iq_sample_fifo import iq_rx_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,

  // Write side, from the deframer
  input  logic       i_push,
  input  iq_sample_t i_wr_sample,

  // Read side, towards the SMI reader
  input  logic       i_pull,
  output iq_sample_t o_rd_sample,  // Valid on the cycle after a pull

  output logic       o_full,
  output logic       o_empty
);

  // ==========================================================================
  // Storage and pointers
  // ==========================================================================
  iq_sample_t r_mem [FIFO_DEPTH];

  // One extra bit on each pointer tells full from empty
  logic [FIFO_ADDR_W:0]   r_wr_ptr;
  logic [FIFO_ADDR_W:0]   r_rd_ptr;
  logic [FIFO_ADDR_W-1:0] w_wr_addr;
  logic [FIFO_ADDR_W-1:0] w_rd_addr;

  logic       w_full;
  logic       w_empty;
  logic       w_do_push;
  logic       w_do_pull;
  iq_sample_t r_rd_sample;

  assign w_wr_addr = r_wr_ptr[FIFO_ADDR_W-1:0];
  assign w_rd_addr = r_rd_ptr[FIFO_ADDR_W-1:0];

  // Same address, wrap bits differ
  assign w_full  = (r_wr_ptr[FIFO_ADDR_W] != r_rd_ptr[FIFO_ADDR_W]) &&
                   (w_wr_addr == w_rd_addr);
  assign w_empty = (r_wr_ptr == r_rd_ptr);

  // Guard the pointers here, callers may ask at the wrong time
  assign w_do_push = i_push && !w_full;
  assign w_do_pull = i_pull && !w_empty;

  // ==========================================================================
  // Memory write and registered read
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (w_do_push) begin
      r_mem[w_wr_addr] <= i_wr_sample;
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (w_do_pull) begin
      r_rd_sample <= r_mem[w_rd_addr];  // Holds until the next pull
    end
  end

  // Pointer update
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_do_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_do_pull) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
    end
  end

  assign o_rd_sample = r_rd_sample;
  assign o_full      = w_full;
  assign o_empty     = w_empty;

endmodule

/* src/lvds_rx_deframer.sv */
`timescale 1ns/1ps

module lvds_rx_deframer import iq_rx_pkg::*; (
  input  logic        i_glob_clock,
  input  logic        i_rst_b,

  // Modem lanes, two bits per clock, d0 first
  input  logic        i_rx_09_d0,
  input  logic        i_rx_09_d1,
  input  logic        i_rx_24_d0,
  input  logic        i_rx_24_d1,
  input  rx_channel_e i_channel,

  // Sample FIFO write side
  input  logic        i_fifo_full,
  output logic        o_push,
  output iq_sample_t  o_sample
);

  // ==========================================================================
  // Lane selection
  // ==========================================================================
  logic [1:0]          w_dibit;       // {d0, d1}, d0 is the MSB of the pair
  logic [SAMPLE_W-1:0] w_shift_next;
  logic                w_channel_change;
  logic                w_frame_last;  // Sixteenth dibit on this clock
  logic                w_q_sync_ok;

  logic [SAMPLE_W-1:0] r_shift;
  logic [DF_CNT_W-1:0] r_cnt;
  deframer_state_e     r_state;
  rx_channel_e         r_prev_channel;
  logic                r_push;

  // The 2.4 GHz lane comes in on the N pin, so both bits get flipped back
  assign w_dibit = (i_channel == RX_CH_24) ? ~{i_rx_24_d0, i_rx_24_d1}
                                           : {i_rx_09_d0, i_rx_09_d1};

  assign w_channel_change = (i_channel != r_prev_channel);

  // ==========================================================================
  // Frame assembly
  // ==========================================================================
  assign w_shift_next = {r_shift[SAMPLE_W-3:0], w_dibit};  // New dibit enters at LSB

  assign w_frame_last = (r_state == DF_COLLECT) &&
                        (r_cnt == DF_CNT_W'(DIBITS_PER_FRAME - 1));

  // Q marker lands at bits 15:14 once the full word is in
  assign w_q_sync_ok = (w_shift_next[HALF_W-1:HALF_W-2] == SYNC_Q);

  // Free running shifter
  // After sixteen dibits every bit is fresh, older bits just fall off the top
  always_ff @(posedge i_glob_clock) begin
    r_shift <= w_shift_next;
  end

  // Hunt / collect control
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_state        <= DF_HUNT;
      r_cnt          <= '0;
      r_push         <= 1'b0;
      r_prev_channel <= RX_CH_09;
    end else begin
      r_prev_channel <= i_channel;
      r_push         <= 1'b0;  // One cycle strobe

      if (w_channel_change) begin
        // Partial frame belongs to the old lane, start over
        r_state <= DF_HUNT;
        r_cnt   <= '0;
      end else begin
        case (r_state)
          DF_HUNT: begin
            if (w_dibit == SYNC_I) begin  // I marker opens a frame
              r_state <= DF_COLLECT;
              r_cnt   <= DF_CNT_W'(1);
            end
          end

          DF_COLLECT: begin
            if (w_frame_last) begin
              // Back in hunt right away so frames may follow back to back
              r_state <= DF_HUNT;
              r_cnt   <= '0;
              r_push  <= w_q_sync_ok && !i_fifo_full;  // Bad Q sync or no room drops it
            end else begin
              r_cnt <= r_cnt + 1'b1;
            end
          end

          default: begin
            r_state <= DF_HUNT;
            r_cnt   <= '0;
          end
        endcase
      end
    end
  end

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign o_push = r_push;

  // While push is high the shifter still holds the completed frame
  assign o_sample = iq_sample_t'(r_shift);

endmodule

/* src/iq_rx_pkg.sv */
package iq_rx_pkg;

  // ==========================================================================
  // Frame format on the modem lanes
  // ==========================================================================
  localparam int SAMPLE_W         = 32;                        // One I/Q word
  localparam int HALF_W           = 16;                        // I half, Q half
  localparam int DIBITS_PER_FRAME = 16;                        // Clocks per frame
  localparam int DF_CNT_W         = $clog2(DIBITS_PER_FRAME);  // Dibit counter

  localparam logic [1:0] SYNC_I = 2'b10;  // Top of the I half
  localparam logic [1:0] SYNC_Q = 2'b01;  // Top of the Q half

  // ==========================================================================
  // Sample FIFO and SMI byte stream
  // ==========================================================================
  localparam int FIFO_ADDR_W      = 10;
  localparam int FIFO_DEPTH       = 1 << FIFO_ADDR_W;          // 1024 samples
  localparam int BYTES_PER_SAMPLE = 4;
  localparam int SMI_BYTE_W       = SAMPLE_W / BYTES_PER_SAMPLE;
  localparam int BYTE_IDX_W       = $clog2(BYTES_PER_SAMPLE);

  // I sits in the upper half, same as the bit order on the wire
  typedef struct packed {
    logic [HALF_W-1:0] i;
    logic [HALF_W-1:0] q;
  } iq_sample_t;

  typedef enum logic {
    RX_CH_09 = 1'b0,  // 0.9 GHz lane
    RX_CH_24 = 1'b1   // 2.4 GHz lane, inverted on the board
  } rx_channel_e;

  typedef enum logic {
    DF_HUNT,
    DF_COLLECT
  } deframer_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_SERVE
  } reader_state_e;

endpackage
